// ==== hw/execute_params.svh ====
`ifndef EXECUTE_PARAMS_SVH
`define EXECUTE_PARAMS_SVH

//////////////////////////////////////////////////
// Cluster sizing
//////////////////////////////////////////////////

// Parallel execute lanes per issue group
`define EX_LANES 2

// Data and address width
`define EX_XLEN 32

`endif

// ==== hw/execute_pkg.sv ====
package execute_pkg;

  // ALU result select
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_sll    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_slt    = 4'd8,
    alu_sltu   = 4'd9,
    alu_pass_b = 4'd10,
    alu_link   = 4'd11
  } alu_op_e;

  // CSR update form, same code as funct3
  typedef enum logic [2:0] {
    csr_none = 3'b000,
    csr_rw   = 3'b001,
    csr_rs   = 3'b010,
    csr_rc   = 3'b011,
    csr_rwi  = 3'b101,
    csr_rsi  = 3'b110,
    csr_rci  = 3'b111
  } csr_op_e;

  // RV32I major opcodes handled here
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_system = 7'b1110011
  } rv_opcode_e;

endpackage

// ==== hw/execute_if.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

//////////////////////////////////////////////////
// Decoder to lane
//////////////////////////////////////////////////

interface ex_ctrl_if;
  import execute_pkg::*;

  // Group strobe, one cycle
  logic valid;
  alu_op_e alu_op;
  csr_op_e csr_op;
  // Operands
  logic [`EX_XLEN-1:0] a;
  logic [`EX_XLEN-1:0] b;
  // Lane's own pc, already offset by lane index
  logic [`EX_XLEN-1:0] pc;
  logic [`EX_XLEN-1:0] csr_in;

  modport dec (output valid, alu_op, csr_op, a, b, pc, csr_in);
  modport lane (input valid, alu_op, csr_op, a, b, pc, csr_in);
endinterface

//////////////////////////////////////////////////
// Lane to collector
//////////////////////////////////////////////////

interface ex_res_if;
  // Strobe aligned with the data
  logic valid;
  logic [`EX_XLEN-1:0] res;
  // Signed less-than flag for later branch logic
  logic lt;
  // New CSR value, reported only
  logic [`EX_XLEN-1:0] csr_res;

  modport lane (output valid, res, lt, csr_res);
  modport col (input valid, res, lt, csr_res);
endinterface

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

module alu (
  input  logic [`EX_XLEN-1:0] a,
  input  logic [`EX_XLEN-1:0] b,
  input  logic [`EX_XLEN-1:0] pc,
  input  execute_pkg::alu_op_e alu_op,
  input  execute_pkg::csr_op_e csr_op,
  input  logic [`EX_XLEN-1:0] csr_in,
  output logic [`EX_XLEN-1:0] res,
  output logic                lt,
  output logic [`EX_XLEN-1:0] csr_res
);
  import execute_pkg::*;

  logic [4:0] shamt;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt    = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  //////////////////////////////////////////////////
  // Main result
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      alu_add:    res = a + b;
      // Wraps modulo 2^32
      alu_sub:    res = a - b;
      alu_and:    res = a & b;
      alu_or:     res = a | b;
      alu_xor:    res = a ^ b;
      alu_sll:    res = a << shamt;
      alu_srl:    res = a >> shamt;
      // Sign bit fills from the left
      alu_sra:    res = $unsigned($signed(a) >>> shamt);
      alu_slt:    res = {{(`EX_XLEN-1){1'b0}}, lt};
      alu_sltu:   res = {{(`EX_XLEN-1){1'b0}}, lt_u};
      // LUI, AUIPC with pc already added
      alu_pass_b: res = b;
      // 32-bit encodings only, step is always 4
      alu_link:   res = pc + `EX_XLEN'(4);
      default:    res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // CSR new value
  //////////////////////////////////////////////////

  always_comb begin
    case (csr_op)
      // Register forms take a
      csr_rw:  csr_res = a;
      csr_rs:  csr_res = csr_in | a;
      csr_rc:  csr_res = csr_in & ~a;
      // Immediate forms take zimm on b
      csr_rwi: csr_res = b;
      csr_rsi: csr_res = csr_in | b;
      csr_rci: csr_res = csr_in & ~b;
      default: csr_res = '0;
    endcase
  end

endmodule

// ==== hw/execute_lane.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

module execute_lane (
  input  logic   clk,
  input  logic   rst,
  ex_ctrl_if.lane ctrl,
  ex_res_if.lane  result
);

  // Raw ALU outputs
  logic [`EX_XLEN-1:0] alu_res;
  logic                alu_lt;
  logic [`EX_XLEN-1:0] alu_csr;

  alu u_alu (
    .a       (ctrl.a),
    .b       (ctrl.b),
    .pc      (ctrl.pc),
    .alu_op  (ctrl.alu_op),
    .csr_op  (ctrl.csr_op),
    .csr_in  (ctrl.csr_in),
    .res     (alu_res),
    .lt      (alu_lt),
    .csr_res (alu_csr)
  );

  // Stage boundary, new group every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid   <= 1'b0;
      result.res     <= '0;
      result.lt      <= 1'b0;
      result.csr_res <= '0;
    end else begin
      result.valid   <= ctrl.valid;
      result.res     <= alu_res;
      result.lt      <= alu_lt;
      result.csr_res <= alu_csr;
    end
  end

endmodule

// ==== hw/issue_decode.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

module issue_decode (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_valid,
  input  logic [`EX_LANES-1:0][31:0]          inst,
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0]  rs1_val,
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0]  rs2_val,
  input  logic [`EX_XLEN-1:0]                 pc,
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0]  csr_in,
  ex_ctrl_if.dec                              ctrl [`EX_LANES]
);
  import execute_pkg::*;

  // funct3 to ALU op, alt picks sub or sra
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  for (genvar i = 0; i < `EX_LANES; i++) begin : g_dec
    rv_opcode_e          opc;
    logic [2:0]          funct3;
    logic                f7b5;
    logic [`EX_XLEN-1:0] imm_i;
    logic [`EX_XLEN-1:0] imm_u;
    logic [`EX_XLEN-1:0] zimm;
    logic [`EX_XLEN-1:0] lane_pc;
    alu_op_e             dec_alu;
    csr_op_e             dec_csr;
    logic [`EX_XLEN-1:0] dec_a;
    logic [`EX_XLEN-1:0] dec_b;

    // Field extraction
    assign opc    = rv_opcode_e'(inst[i][6:0]);
    assign funct3 = inst[i][14:12];
    assign f7b5   = inst[i][30];
    assign imm_i  = {{20{inst[i][31]}}, inst[i][31:20]};
    assign imm_u  = {inst[i][31:12], 12'b0};
    // rs1 field as unsigned CSR immediate
    assign zimm   = {27'b0, inst[i][19:15]};
    // Lane i sits 4*i bytes past the group pc
    assign lane_pc = pc + `EX_XLEN'(4 * i);

    always_comb begin
      // Unknown encodings give a zero result
      dec_alu = alu_add;
      dec_csr = csr_none;
      dec_a   = '0;
      dec_b   = '0;
      case (opc)
        opc_op: begin
          dec_alu = f3_to_alu(funct3, f7b5);
          dec_a   = rs1_val[i];
          dec_b   = rs2_val[i];
        end
        opc_op_imm: begin
          // No subi, alt bit only matters for shifts
          dec_alu = f3_to_alu(funct3, f7b5 && (funct3 == 3'b101));
          dec_a   = rs1_val[i];
          dec_b   = imm_i;
        end
        opc_lui: begin
          dec_alu = alu_pass_b;
          dec_b   = imm_u;
        end
        opc_auipc: begin
          // Full pc folded into b here
          dec_alu = alu_pass_b;
          dec_b   = imm_u + lane_pc;
        end
        opc_jal, opc_jalr: begin
          // Link only, target is not computed here
          dec_alu = alu_link;
          dec_a   = rs1_val[i];
          dec_b   = imm_i;
        end
        opc_system: begin
          // funct3 000 and 100 are not CSR forms
          if (funct3[1:0] != 2'b00) begin
            dec_alu = alu_pass_b;
            dec_csr = csr_op_e'(funct3);
            dec_a   = rs1_val[i];
            dec_b   = funct3[2] ? zimm : rs2_val[i];
          end
        end
        default: ;
      endcase
    end

    // Stage register toward the lane
    always_ff @(posedge clk) begin
      if (rst) begin
        ctrl[i].valid  <= 1'b0;
        ctrl[i].alu_op <= alu_add;
        ctrl[i].csr_op <= csr_none;
        ctrl[i].a      <= '0;
        ctrl[i].b      <= '0;
        ctrl[i].pc     <= '0;
        ctrl[i].csr_in <= '0;
      end else begin
        ctrl[i].valid  <= in_valid;
        ctrl[i].alu_op <= dec_alu;
        ctrl[i].csr_op <= dec_csr;
        ctrl[i].a      <= dec_a;
        ctrl[i].b      <= dec_b;
        ctrl[i].pc     <= lane_pc;
        ctrl[i].csr_in <= csr_in[i];
      end
    end
  end

endmodule

// ==== hw/result_collect.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

module result_collect (
  input  logic                               clk,
  input  logic                               rst,
  ex_res_if.col                              result [`EX_LANES],
  output logic                               out_valid,
  output logic [`EX_LANES-1:0][`EX_XLEN-1:0] res,
  output logic [`EX_LANES-1:0]               lt,
  output logic [`EX_LANES-1:0][`EX_XLEN-1:0] csr_res
);

  // Lane results gathered into plain arrays
  logic [`EX_XLEN-1:0] lane_res [`EX_LANES];
  logic                lane_lt  [`EX_LANES];
  logic [`EX_XLEN-1:0] lane_csr [`EX_LANES];

  for (genvar i = 0; i < `EX_LANES; i++) begin : g_gather
    assign lane_res[i] = result[i].res;
    assign lane_lt[i]  = result[i].lt;
    assign lane_csr[i] = result[i].csr_res;
  end

  //////////////////////////////////////////////////
  // Output group register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      res       <= '0;
      lt        <= '0;
      csr_res   <= '0;
    end else begin
      // Lanes run in lockstep, lane 0 speaks for all
      out_valid <= result[0].valid;
      for (int k = 0; k < `EX_LANES; k++) begin
        res[k]     <= lane_res[k];
        lt[k]      <= lane_lt[k];
        csr_res[k] <= lane_csr[k];
      end
    end
  end

endmodule

// ==== hw/execute_cluster.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

module execute_cluster (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               in_valid,
  input  logic [`EX_LANES-1:0][31:0]         inst,
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0] rs1_val,
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0] rs2_val,
  input  logic [`EX_XLEN-1:0]                pc,
  input  logic [`EX_LANES-1:0][`EX_XLEN-1:0] csr_in,
  output logic                               out_valid,
  output logic [`EX_LANES-1:0][`EX_XLEN-1:0] res,
  output logic [`EX_LANES-1:0]               lt,
  output logic [`EX_LANES-1:0][`EX_XLEN-1:0] csr_res
);

  // Per-lane buses between stages
  ex_ctrl_if ctrl_bus [`EX_LANES] ();
  ex_res_if  res_bus  [`EX_LANES] ();

  // Stage 1, decode and operand select
  issue_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .inst     (inst),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .pc       (pc),
    .csr_in   (csr_in),
    .ctrl     (ctrl_bus)
  );

  // Stage 2, one ALU per lane
  for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
    execute_lane u_lane (
      .clk    (clk),
      .rst    (rst),
      .ctrl   (ctrl_bus[i]),
      .result (res_bus[i])
    );
  end

  // Stage 3, output group
  result_collect u_collect (
    .clk       (clk),
    .rst       (rst),
    .result    (res_bus),
    .out_valid (out_valid),
    .res       (res),
    .lt        (lt),
    .csr_res   (csr_res)
  );

endmodule

// ==== bench/tb_execute_cluster.sv ====
`timescale 1ns/10ps
`include "execute_params.svh"

module tb_execute_cluster;

  localparam int NROWS        = 12;
  localparam int RESET_CYCLES = 3;
  // Edge N in, out_valid after edge N+3
  localparam int LATENCY      = 3;

  logic                               clk;
  logic                               rst;
  logic                               in_valid;
  logic [`EX_LANES-1:0][31:0]         inst;
  logic [`EX_LANES-1:0][`EX_XLEN-1:0] rs1_val;
  logic [`EX_LANES-1:0][`EX_XLEN-1:0] rs2_val;
  logic [`EX_XLEN-1:0]                pc;
  logic [`EX_LANES-1:0][`EX_XLEN-1:0] csr_in;
  logic                               out_valid;
  logic [`EX_LANES-1:0][`EX_XLEN-1:0] res;
  logic [`EX_LANES-1:0]               lt;
  logic [`EX_LANES-1:0][`EX_XLEN-1:0] csr_res;

  // Stimulus and expected values, one group per row
  string       row_name [NROWS];
  logic [31:0] row_pc   [NROWS];
  int          row_gap  [NROWS];
  logic [31:0] t_inst   [NROWS][`EX_LANES];
  logic [31:0] t_rs1    [NROWS][`EX_LANES];
  logic [31:0] t_rs2    [NROWS][`EX_LANES];
  logic [31:0] t_csr    [NROWS][`EX_LANES];
  logic [31:0] e_res    [NROWS][`EX_LANES];
  logic        e_lt     [NROWS][`EX_LANES];
  logic [31:0] e_csr    [NROWS][`EX_LANES];

  // Groups in flight, row index and cycle of arrival
  int exp_row_q [$];
  int exp_cyc_q [$];

  int cycle = 0;
  int timeout_limit = 1000;
  int val_errs = 0;
  int oth_errs = 0;
  int mon_row;
  int mon_cyc;

  execute_cluster dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .inst      (inst),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .pc        (pc),
    .csr_in    (csr_in),
    .out_valid (out_valid),
    .res       (res),
    .lt        (lt),
    .csr_res   (csr_res)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic set_group(input int r, input string name, input logic [31:0] gpc,
                           input int gap);
    row_name[r] = name;
    row_pc[r]   = gpc;
    row_gap[r]  = gap;
  endtask

  task automatic set_lane(input int r, input int l, input logic [31:0] ins,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input logic [31:0] xres,
                          input logic xlt, input logic [31:0] xcsr);
    t_inst[r][l] = ins;
    t_rs1[r][l]  = a;
    t_rs2[r][l]  = b;
    t_csr[r][l]  = c;
    e_res[r][l]  = xres;
    e_lt[r][l]   = xlt;
    e_csr[r][l]  = xcsr;
  endtask

  ////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////

  task automatic fill_table();
    // Lane args: inst, rs1, rs2, csr_in, then expected res, lt, csr_res
    set_group(0, "add_sub", 'h1000, 0);
    set_lane(0, 0, 'h002081b3, 'h5, 'h3, 'h0, 'h8, 0, 'h0);
    set_lane(0, 1, 'h402081b3, 'h3, 'h5, 'h0, 'hfffffffe, 1, 'h0);
    set_group(1, "and_or", 'h1000, 0);
    set_lane(1, 0, 'h0020f1b3, 'hf0f0f0f0, 'h0ff00ff0, 'h0, 'h00f000f0, 1, 'h0);
    set_lane(1, 1, 'h0020e1b3, 'hf0f0f0f0, 'h0ff00ff0, 'h0, 'hfff0fff0, 1, 'h0);
    // Shift amount keeps only b[4:0]
    set_group(2, "xor_sll", 'h1000, 0);
    set_lane(2, 0, 'h0020c1b3, 'haaaa5555, 'hffff0000, 'h0, 'h55555555, 1, 'h0);
    set_lane(2, 1, 'h002091b3, 'h1, 'h24, 'h0, 'h10, 1, 'h0);
    set_group(3, "srl_sra", 'h1000, 2);
    set_lane(3, 0, 'h0020d1b3, 'h80000000, 'h4, 'h0, 'h08000000, 1, 'h0);
    set_lane(3, 1, 'h4020d1b3, 'h80000000, 'h4, 'h0, 'hf8000000, 1, 'h0);
    // -1 below 1 signed, above it unsigned
    set_group(4, "slt_sltu", 'h1000, 0);
    set_lane(4, 0, 'h0020a1b3, 'hffffffff, 'h1, 'h0, 'h1, 1, 'h0);
    set_lane(4, 1, 'h0020b1b3, 'hffffffff, 'h1, 'h0, 'h0, 1, 'h0);
    set_group(5, "addi_lui", 'h1000, 0);
    set_lane(5, 0, 'hff008193, 'h100, 'h77, 'h0, 'hf0, 0, 'h0);
    set_lane(5, 1, 'h123451b7, 'h55, 'h0, 'h0, 'h12345000, 1, 'h0);
    // Lane 1 sits at pc plus 4
    set_group(6, "auipc", 'h2000, 0);
    set_lane(6, 0, 'h00001197, 'h0, 'h0, 'h0, 'h3000, 1, 'h0);
    set_lane(6, 1, 'h00001197, 'h0, 'h0, 'h0, 'h3004, 1, 'h0);
    set_group(7, "jal_jalr", 'h400, 1);
    set_lane(7, 0, 'h008000ef, 'h0, 'h0, 'h0, 'h404, 1, 'h0);
    set_lane(7, 1, 'h004280e7, 'h1000, 'h0, 'h0, 'h408, 0, 'h0);
    set_group(8, "csr_rw_rs", 'h1000, 0);
    set_lane(8, 0, 'h300091f3, 'h12345678, 'h0, 'h0000ff00, 'h0, 0, 'h12345678);
    set_lane(8, 1, 'h3000a1f3, 'hff, 'h0, 'h0000ff00, 'h0, 0, 'h0000ffff);
    set_group(9, "csr_rc_rwi", 'h1000, 0);
    set_lane(9, 0, 'h3000b1f3, 'h0000f00f, 'h0, 'hffffffff, 'h0, 0, 'hffff0ff0);
    set_lane(9, 1, 'h3002d1f3, 'h0, 'h0, 'hdead0000, 'h5, 1, 'h5);
    set_group(10, "csr_rsi_rci", 'h1000, 0);
    set_lane(10, 0, 'h300561f3, 'h0, 'h0, 'h100, 'ha, 1, 'h10a);
    set_lane(10, 1, 'h3007f1f3, 'h0, 'h0, 'hff, 'hf, 1, 'hf0);
    // Load opcode and ecall, neither is handled
    set_group(11, "unknown", 'h1000, 0);
    set_lane(11, 0, 'h00012183, 'h55, 'h66, 'h1234, 'h0, 0, 'h0);
    set_lane(11, 1, 'h00000073, 'h55, 'h66, 'h1234, 'h0, 0, 'h0);
  endtask

  task automatic check_word(input string name, input string field,
                            input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error: %s %s expected %h actual %h", name, field, exp, act);
      val_errs++;
    end
  endtask

  task automatic report_counts();
    $display("Error counts: %0d wrong values, %0d other failures", val_errs, oth_errs);
  endtask

  ////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////

  initial begin
    int gap_sum;
    gap_sum  = 0;
    rst      = 1'b1;
    in_valid = 1'b0;
    inst     = '0;
    rs1_val  = '0;
    rs2_val  = '0;
    pc       = '0;
    csr_in   = '0;
    fill_table();
    for (int r = 0; r < NROWS; r++) begin
      gap_sum += row_gap[r];
    end
    timeout_limit = NROWS + gap_sum + RESET_CYCLES + LATENCY + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst = 1'b0;
    for (int r = 0; r < NROWS; r++) begin
      @(posedge clk);
      #2;
      in_valid = 1'b1;
      pc       = row_pc[r];
      for (int l = 0; l < `EX_LANES; l++) begin
        inst[l]    = t_inst[r][l];
        rs1_val[l] = t_rs1[r][l];
        rs2_val[l] = t_rs2[r][l];
        csr_in[l]  = t_csr[r][l];
      end
      // Driven after edge N, out_valid after edge N+3
      exp_row_q.push_back(r);
      exp_cyc_q.push_back(cycle + LATENCY);
      repeat (row_gap[r]) begin
        @(posedge clk);
        #2 in_valid = 1'b0;
      end
    end
    @(posedge clk);
    #2 in_valid = 1'b0;
    while (exp_row_q.size() != 0) @(negedge clk);
    // Idle tail, no stray strobes
    repeat (LATENCY + 2) @(negedge clk);
    report_counts();
    if (val_errs == 0 && oth_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  ////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////

  // Sampled on the falling edge, outputs settled
  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_row_q.size() == 0) begin
        $display("out_valid was high at cycle %0d with no group in flight", cycle);
        oth_errs++;
      end else begin
        mon_row = exp_row_q.pop_front();
        mon_cyc = exp_cyc_q.pop_front();
        check_word(row_name[mon_row], "out cycle", mon_cyc, cycle);
        for (int l = 0; l < `EX_LANES; l++) begin
          check_word(row_name[mon_row], $sformatf("res%0d", l), e_res[mon_row][l], res[l]);
          check_word(row_name[mon_row], $sformatf("lt%0d", l),
                     {31'b0, e_lt[mon_row][l]}, {31'b0, lt[l]});
          check_word(row_name[mon_row], $sformatf("csr_res%0d", l),
                     e_csr[mon_row][l], csr_res[l]);
        end
      end
    end
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_limit) begin
      $display("Timeout after %0d cycles, %0d groups never came out",
               cycle, exp_row_q.size());
      oth_errs++;
      report_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

// ==== execute_cluster.f ====
+incdir+hw
hw/execute_pkg.sv
hw/execute_if.sv
hw/alu.sv
hw/execute_lane.sv
hw/issue_decode.sv
hw/result_collect.sv
hw/execute_cluster.sv
bench/tb_execute_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --top-module tb_execute_cluster \
  -f execute_cluster.f

./obj_dir/Vtb_execute_cluster | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  echo "run_sim.sh: pass message not found in sim.log"
  exit 1
fi
